// File: verilog/reindeer_pkg.sv
// widths, opcodes and funct codes of the kept RV32I subset
// instruction word union and the structs passed between units

package reindeer_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int MEM_ADDR_BITS = 10;
    localparam int PC_BITWIDTH   = MEM_ADDR_BITS + 2;
    localparam int SHAMT_BITS    = $clog2(XLEN);

    // ------------------------------
    // opcodes and function codes
    // ------------------------------
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // selects SUB and SRA
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [PC_BITWIDTH-1:0]   pc_t;
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    // ------------------------------
    // instruction word views
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // LUI immediate is imm12, rs1 and funct3 read together
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } iu_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        iu_fmt_t iu;
    } instr_u;

    // decoded controls for the ALU
    typedef struct packed {
        logic [2:0] funct3;
        logic       alt;
        logic       use_imm;
        logic       is_lui;
        xlen_t      imm;
        reg_addr_t  rd;
        logic       illegal;
    } alu_ctl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        xlen_t     data;
    } wb_req_t;

    // debugger register port
    typedef struct packed {
        reg_addr_t read_addr;
        logic      we;
        reg_addr_t write_addr;
        xlen_t     write_data;
    } ocd_reg_req_t;

endpackage

// File: verilog/reindeer_controller.sv
// run/pause FSM of the core
// sequences fetch, decode, execute and write-back strobes

`timescale 1ns/1ps
`default_nettype none

module reindeer_controller (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  reindeer_pkg::pc_t start_address_i,
    input  logic              mem_read_ack_i,
    input  logic              illegal_i,
    output logic              fetch_init_o,
    output reindeer_pkg::pc_t init_addr_o,
    output logic              fetch_next_o,
    output logic              decode_en_o,
    output logic              exe_en_o,
    output logic              wb_en_o,
    output logic              paused_o
);
    import reindeer_pkg::*;

    typedef enum logic [2:0] {
        ST_PAUSED,
        ST_FETCH,
        ST_WAIT,
        ST_DECODE,
        ST_EXECUTE
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_PAUSED:  if (start_i) state_d = ST_FETCH;
            ST_FETCH:   state_d = ST_WAIT;
            // the ack ends a memory wait of varying length
            ST_WAIT:    if (mem_read_ack_i) state_d = ST_DECODE;
            ST_DECODE:  state_d = ST_EXECUTE;
            ST_EXECUTE: state_d = illegal_i ? ST_PAUSED : ST_FETCH;
            default:    state_d = ST_PAUSED;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_PAUSED;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // strobes to the units
    // ------------------------------
    assign fetch_init_o = (state_q == ST_PAUSED) && start_i;
    assign init_addr_o  = start_address_i;
    assign decode_en_o  = (state_q == ST_DECODE);
    assign exe_en_o     = (state_q == ST_EXECUTE);

    // illegal opcode halts with no write-back and the PC held
    assign wb_en_o      = (state_q == ST_EXECUTE) && !illegal_i;
    assign fetch_next_o = (state_q == ST_EXECUTE) && !illegal_i;

    assign paused_o = (state_q == ST_PAUSED);

endmodule

`default_nettype wire

// File: verilog/reindeer_fetch.sv
// program counter and instruction register
// issues the code memory read strobe

`timescale 1ns/1ps
`default_nettype none

module reindeer_fetch (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    fetch_init_i,
    input  reindeer_pkg::pc_t       init_addr_i,
    input  logic                    fetch_next_i,
    input  reindeer_pkg::xlen_t     mem_read_data_i,
    input  logic                    mem_read_ack_i,
    output reindeer_pkg::mem_addr_t mem_addr_o,
    output logic                    mem_read_en_o,
    output reindeer_pkg::instr_u    ir_o,
    output reindeer_pkg::pc_t       pc_o
);
    import reindeer_pkg::*;

    pc_t    pc_q;
    instr_u ir_q;
    logic   read_en_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q      <= '0;
            ir_q      <= '0;
            read_en_q <= 1'b0;
        end else begin
            // one read per init or step
            read_en_q <= fetch_init_i | fetch_next_i;

            if (fetch_init_i) begin
                pc_q <= init_addr_i;
            end else if (fetch_next_i) begin
                pc_q <= pc_q + PC_BITWIDTH'(4);
            end

            if (mem_read_ack_i) begin
                ir_q <= mem_read_data_i;
            end
        end
    end

    // word address of the byte PC
    assign mem_addr_o    = pc_q[PC_BITWIDTH-1:2];
    assign mem_read_en_o = read_en_q;
    assign ir_o          = ir_q;
    assign pc_o          = pc_q;

endmodule

`default_nettype wire

// File: verilog/reindeer_decode.sv
// instruction decode for OP-IMM, OP and LUI
// register addresses and registered ALU controls

`timescale 1ns/1ps
`default_nettype none

module reindeer_decode (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   decode_en_i,
    input  reindeer_pkg::instr_u   ir_i,
    output reindeer_pkg::reg_addr_t rs1_o,
    output reindeer_pkg::reg_addr_t rs2_o,
    output reindeer_pkg::alu_ctl_t ctl_o
);
    import reindeer_pkg::*;

    alu_ctl_t ctl_d;
    alu_ctl_t ctl_q;
    logic     is_shift;

    assign is_shift = (ir_i.iu.funct3 == FUNCT3_SLL) || (ir_i.iu.funct3 == FUNCT3_SR);

    always_comb begin
        ctl_d        = '0;
        ctl_d.funct3 = ir_i.r.funct3;
        ctl_d.rd     = ir_i.r.rd;
        case (ir_i.r.opcode)
            OPCODE_OP: begin
                ctl_d.alt = (ir_i.r.funct7 == FUNCT7_ALT);
            end
            OPCODE_OP_IMM: begin
                ctl_d.use_imm = 1'b1;
                if (is_shift) begin
                    // shamt sits in the rs2 field and SRAI in funct7
                    ctl_d.imm = {{(XLEN-REG_ADDR_BITS){1'b0}}, ir_i.r.rs2};
                    ctl_d.alt = (ir_i.r.funct7 == FUNCT7_ALT);
                end else begin
                    ctl_d.imm = {{(XLEN-12){ir_i.iu.imm12[11]}}, ir_i.iu.imm12};
                end
            end
            OPCODE_LUI: begin
                ctl_d.is_lui = 1'b1;
                ctl_d.imm    = {ir_i.iu.imm12, ir_i.iu.rs1, ir_i.iu.funct3, 12'b0};
            end
            default: begin
                ctl_d.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_q <= '0;
        end else if (decode_en_i) begin
            ctl_q <= ctl_d;
        end
    end

    // register file reads alongside the decode strobe
    assign rs1_o = ir_i.r.rs1;
    assign rs2_o = ir_i.r.rs2;
    assign ctl_o = ctl_q;

endmodule

`default_nettype wire

// File: verilog/reindeer_reg_file.sv
// x1..x31 register file where x0 reads as zero
// second read port and write port go to the debugger while paused

`timescale 1ns/1ps
`default_nettype none

module reindeer_reg_file (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       read_en_i,
    input  reindeer_pkg::reg_addr_t    rs1_i,
    input  reindeer_pkg::reg_addr_t    rs2_i,
    input  logic                       paused_i,
    input  reindeer_pkg::wb_req_t      wb_i,
    input  reindeer_pkg::ocd_reg_req_t ocd_i,
    output reindeer_pkg::xlen_t        rs1_data_o,
    output reindeer_pkg::xlen_t        rs2_data_o,
    output reindeer_pkg::xlen_t        ocd_read_data_o
);
    import reindeer_pkg::*;

    xlen_t     regs [1:31];
    xlen_t     rs1_data_q;
    xlen_t     rs2_data_q;
    reg_addr_t rd2_addr;
    logic      rd2_en;
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;

    // ------------------------------
    // run/pause port selection
    // ------------------------------
    assign rd2_addr = paused_i ? ocd_i.read_addr : rs2_i;
    assign rd2_en   = paused_i | read_en_i;
    assign we       = paused_i ? ocd_i.we : wb_i.we;
    assign waddr    = paused_i ? ocd_i.write_addr : wb_i.addr;
    assign wdata    = paused_i ? ocd_i.write_data : wb_i.data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en_i) begin
            rs1_data_q <= (rs1_i == '0) ? '0 : regs[rs1_i];
        end
        if (rd2_en) begin
            rs2_data_q <= (rd2_addr == '0) ? '0 : regs[rd2_addr];
        end
    end

    assign rs1_data_o      = rs1_data_q;
    assign rs2_data_o      = rs2_data_q;
    assign ocd_read_data_o = rs2_data_q;

endmodule

`default_nettype wire

// File: verilog/reindeer_execute.sv
// ALU for the integer register and immediate groups
// registers the write-back request

`timescale 1ns/1ps
`default_nettype none

module reindeer_execute (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   exe_en_i,
    input  reindeer_pkg::alu_ctl_t ctl_i,
    input  reindeer_pkg::xlen_t    rs1_data_i,
    input  reindeer_pkg::xlen_t    rs2_data_i,
    input  logic                   wb_en_i,
    output reindeer_pkg::wb_req_t  wb_o
);
    import reindeer_pkg::*;

    xlen_t                 op_b;
    xlen_t                 result;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  we_q;
    reg_addr_t             addr_q;
    xlen_t                 data_q;

    assign op_b  = ctl_i.use_imm ? ctl_i.imm : rs2_data_i;
    assign shamt = op_b[SHAMT_BITS-1:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (ctl_i.funct3)
            FUNCT3_ADD:  result = ctl_i.alt ? rs1_data_i - op_b : rs1_data_i + op_b;
            FUNCT3_SLL:  result = rs1_data_i << shamt;
            FUNCT3_SLT:  result = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
            FUNCT3_SLTU: result = {{(XLEN-1){1'b0}}, rs1_data_i < op_b};
            FUNCT3_XOR:  result = rs1_data_i ^ op_b;
            FUNCT3_SR: begin
                if (ctl_i.alt) begin
                    result = $signed(rs1_data_i) >>> shamt;
                end else begin
                    result = rs1_data_i >> shamt;
                end
            end
            FUNCT3_OR:   result = rs1_data_i | op_b;
            default:     result = rs1_data_i & op_b;
        endcase
        // LUI passes the shifted immediate
        if (ctl_i.is_lui) begin
            result = ctl_i.imm;
        end
    end

    // write enable is a one-cycle pulse after execute
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_q <= 1'b0;
        end else begin
            we_q <= exe_en_i && wb_en_i && (ctl_i.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (exe_en_i) begin
            addr_q <= ctl_i.rd;
            data_q <= result;
        end
    end

    assign wb_o = '{we: we_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: verilog/reindeer_core.sv
// top level of the multicycle core
// connects controller, fetch, decode, register file and execute

`timescale 1ns/1ps
`default_nettype none

module reindeer_core (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  reindeer_pkg::pc_t         start_address_i,
    input  reindeer_pkg::xlen_t       mem_read_data_i,
    input  logic                      mem_read_ack_i,
    input  reindeer_pkg::ocd_reg_req_t ocd_reg_i,
    output reindeer_pkg::mem_addr_t   mem_addr_o,
    output logic                      mem_read_en_o,
    output reindeer_pkg::xlen_t       ocd_reg_read_data_o,
    output logic                      paused_o,
    output reindeer_pkg::pc_t         peek_pc_o,
    output reindeer_pkg::xlen_t       peek_ir_o
);
    import reindeer_pkg::*;

    logic      fetch_init;
    pc_t       init_addr;
    logic      fetch_next;
    logic      decode_en;
    logic      exe_en;
    logic      wb_en;
    logic      paused;
    instr_u    ir;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_ctl_t  alu_ctl;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    wb_req_t   wb_req;

    reindeer_controller reindeer_controller_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .start_address_i (start_address_i),
        .mem_read_ack_i  (mem_read_ack_i),
        .illegal_i       (alu_ctl.illegal),
        .fetch_init_o    (fetch_init),
        .init_addr_o     (init_addr),
        .fetch_next_o    (fetch_next),
        .decode_en_o     (decode_en),
        .exe_en_o        (exe_en),
        .wb_en_o         (wb_en),
        .paused_o        (paused)
    );

    reindeer_fetch reindeer_fetch_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .fetch_init_i    (fetch_init),
        .init_addr_i     (init_addr),
        .fetch_next_i    (fetch_next),
        .mem_read_data_i (mem_read_data_i),
        .mem_read_ack_i  (mem_read_ack_i),
        .mem_addr_o      (mem_addr_o),
        .mem_read_en_o   (mem_read_en_o),
        .ir_o            (ir),
        .pc_o            (peek_pc_o)
    );

    reindeer_decode reindeer_decode_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .decode_en_i (decode_en),
        .ir_i        (ir),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .ctl_o       (alu_ctl)
    );

    // operands are read in the same cycle as the decode strobe
    reindeer_reg_file reindeer_reg_file_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .read_en_i       (decode_en),
        .rs1_i           (rs1),
        .rs2_i           (rs2),
        .paused_i        (paused),
        .wb_i            (wb_req),
        .ocd_i           (ocd_reg_i),
        .rs1_data_o      (rs1_data),
        .rs2_data_o      (rs2_data),
        .ocd_read_data_o (ocd_reg_read_data_o)
    );

    reindeer_execute reindeer_execute_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .exe_en_i   (exe_en),
        .ctl_i      (alu_ctl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_en_i    (wb_en),
        .wb_o       (wb_req)
    );

    assign paused_o  = paused;
    assign peek_ir_o = ir;

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// testbench clock and reset source
// 8 ns clock, reset held low for the first two cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    localparam real HALF_PERIOD = 4.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// File: sim/tb_reindeer.sv
// testbench of the multicycle core
// code memory model, program generator, ISA reference model
// register compare over the debugger port and a watchdog

`timescale 1ns/1ps

module tb_reindeer;
    import reindeer_pkg::*;

    localparam int    PROG_LEN    = 40;
    localparam pc_t   START_A     = 12'h000;
    localparam pc_t   START_B     = 12'h400;
    // SYSTEM opcode with rd = x30 lies outside the kept groups
    localparam xlen_t HALT_WORD   = 32'h0000_0f73;
    localparam int    JUNK_CYCLES = 16;
    // per instruction up to 4 cycles of memory latency plus 4 of sequencing
    localparam int    WATCHDOG_CYCLES = 2 * (PROG_LEN + 1) * (4 + 4) + 1000;

    logic         clk;
    logic         arst_n;
    logic         start_i;
    pc_t          start_address_i;
    xlen_t        mem_read_data_i;
    logic         mem_read_ack_i;
    ocd_reg_req_t ocd_reg;
    mem_addr_t    mem_addr;
    logic         mem_read_en;
    xlen_t        ocd_read_data;
    logic         paused;
    pc_t          peek_pc;
    xlen_t        peek_ir;

    xlen_t     code_mem [0:(1 << MEM_ADDR_BITS)-1];
    xlen_t     model_regs [0:31];
    integer    seed = 32'hcf9c_41f5;
    int        mismatch_count = 0;
    int        failure_count = 0;
    logic      started = 1'b0;
    logic      first_fetch_armed = 1'b0;
    mem_addr_t first_fetch_addr = '0;
    logic      compare_req = 1'b0;

    tb_clock_gen clock_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    reindeer_core dut_i (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .start_i             (start_i),
        .start_address_i     (start_address_i),
        .mem_read_data_i     (mem_read_data_i),
        .mem_read_ack_i      (mem_read_ack_i),
        .ocd_reg_i           (ocd_reg),
        .mem_addr_o          (mem_addr),
        .mem_read_en_o       (mem_read_en),
        .ocd_reg_read_data_o (ocd_read_data),
        .paused_o            (paused),
        .peek_pc_o           (peek_pc),
        .peek_ir_o           (peek_ir)
    );

    // ------------------------------
    // checks
    // ------------------------------
    task automatic check_word(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got %08h, expected %08h", name, actual, expected);
        end
    endtask

    task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got %03h, expected %03h", name, actual, expected);
        end
    endtask

    // ------------------------------
    // ISA reference model
    // ------------------------------
    // runs from start_pc on model_regs and returns the PC of the halting word
    function automatic pc_t run_model(input pc_t start_pc);
        pc_t   pc;
        xlen_t w;
        xlen_t a;
        xlen_t b;
        xlen_t res;
        logic  alt;
        int    steps;
        pc = start_pc;
        for (steps = 0; steps < (1 << MEM_ADDR_BITS); steps++) begin
            w = code_mem[pc[PC_BITWIDTH-1:2]];
            if (w[6:0] != OPCODE_OP && w[6:0] != OPCODE_OP_IMM && w[6:0] != OPCODE_LUI) begin
                return pc;
            end
            a = model_regs[w[19:15]];
            if (w[6:0] == OPCODE_OP) begin
                b   = model_regs[w[24:20]];
                alt = w[30];
            end else begin
                b   = {{20{w[31]}}, w[31:20]};
                alt = w[30] && (w[14:12] == FUNCT3_SR);
            end
            case (w[14:12])
                FUNCT3_ADD:  res = alt ? a - b : a + b;
                FUNCT3_SLL:  res = a << b[4:0];
                FUNCT3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FUNCT3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                FUNCT3_XOR:  res = a ^ b;
                FUNCT3_SR: begin
                    if (alt) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                FUNCT3_OR:   res = a | b;
                default:     res = a & b;
            endcase
            if (w[6:0] == OPCODE_LUI) begin
                res = {w[31:12], 12'h000};
            end
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = res;
            end
            pc = pc + 12'd4;
        end
        return pc;
    endfunction

    // ------------------------------
    // program generator
    // ------------------------------
    task automatic make_instr(input int index, output xlen_t word);
        xlen_t       bits;
        xlen_t       imm_bits;
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        bits     = $random(seed);
        imm_bits = $random(seed);
        kind     = int'(bits[31:24]) % 4;
        rd       = bits[4:0];
        rs1      = bits[9:5];
        rs2      = bits[14:10];
        f3       = bits[17:15];
        imm12    = imm_bits[11:0];
        f7       = 7'h00;
        // every eighth result goes to x0
        if (index % 8 == 7) begin
            rd = 5'd0;
        end
        if ((f3 == FUNCT3_ADD || f3 == FUNCT3_SR) && bits[18]) begin
            f7 = FUNCT7_ALT;
        end
        case (kind)
            0: begin
                word = {f7, rs2, rs1, f3, rd, OPCODE_OP};
            end
            3: begin
                word = {imm_bits[19:0], rd, OPCODE_LUI};
            end
            default: begin
                // shifts carry shamt and SRAI also its funct7
                if (f3 == FUNCT3_SLL) begin
                    imm12 = {7'h00, rs2};
                end else if (f3 == FUNCT3_SR) begin
                    imm12 = {f7, rs2};
                end
                word = {imm12, rs1, f3, rd, OPCODE_OP_IMM};
            end
        endcase
    endtask

    task automatic write_program(input pc_t base, input int count);
        mem_addr_t addr;
        xlen_t     word;
        int        n;
        addr = base[PC_BITWIDTH-1:2];
        for (n = 0; n < count; n++) begin
            make_instr(n, word);
            code_mem[addr] = word;
            addr++;
        end
        code_mem[addr] = HALT_WORD;
    endtask

    // ------------------------------
    // stimulus tasks
    // ------------------------------
    task automatic seed_registers();
        xlen_t value;
        int    r;
        for (r = 0; r < 32; r++) begin
            value = $random(seed);
            @(posedge clk);
            ocd_reg <= '{read_addr: '0, we: 1'b1, write_addr: reg_addr_t'(r), write_data: value};
            model_regs[r] = (r == 0) ? '0 : value;
        end
        @(posedge clk);
        ocd_reg.we <= 1'b0;
    endtask

    task automatic run_program(input pc_t start_pc, input pc_t halt_pc);
        xlen_t junk_addr;
        xlen_t junk_data;
        int    n;
        @(posedge clk);
        first_fetch_armed = 1'b1;
        started           = 1'b1;
        start_i         <= 1'b1;
        start_address_i <= start_pc;
        @(posedge clk);
        start_i <= 1'b0;
        // debugger writes while running are ignored by the core
        for (n = 0; n < JUNK_CYCLES; n++) begin
            junk_addr = $random(seed);
            junk_data = $random(seed);
            ocd_reg.we         <= 1'b1;
            ocd_reg.write_addr <= junk_addr[4:0];
            ocd_reg.write_data <= junk_data;
            @(posedge clk);
        end
        ocd_reg.we <= 1'b0;
        while (!paused) begin
            @(posedge clk);
        end
        check_pc("peek_pc_o", peek_pc, halt_pc);
        check_word("peek_ir_o", peek_ir, HALT_WORD);
        check_pc("mem_addr_o", {first_fetch_addr, 2'b00}, start_pc);
    endtask

    // ------------------------------
    // code memory acking 1 to 4 cycles after each strobe
    // ------------------------------
    initial begin : code_memory
        int        delay;
        mem_addr_t addr;
        mem_read_data_i = '0;
        mem_read_ack_i  = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_read_en) begin
                addr = mem_addr;
                if (first_fetch_armed) begin
                    first_fetch_addr  = addr;
                    first_fetch_armed = 1'b0;
                end
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clk);
                mem_read_data_i <= code_mem[addr];
                mem_read_ack_i  <= 1'b1;
                @(posedge clk);
                mem_read_ack_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && !started && mem_read_en) begin
            failure_count++;
            $display("code read strobe raised before any start");
        end
    end

    // reads every register over the debugger port
    initial begin : register_compare
        int r;
        forever begin
            wait (compare_req);
            for (r = 0; r < 32; r++) begin
                @(posedge clk);
                ocd_reg.read_addr <= reg_addr_t'(r);
                @(posedge clk);
                @(posedge clk);
                check_word($sformatf("x%0d", r), ocd_read_data, model_regs[r]);
            end
            compare_req = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin : main
        pc_t halt_a;
        pc_t halt_b;
        int  i;
        start_i         = 1'b0;
        start_address_i = '0;
        ocd_reg         = '0;
        for (i = 0; i < (1 << MEM_ADDR_BITS); i++) begin
            code_mem[i] = {i[15:0], 9'h000, 7'h7f};
        end

        wait (arst_n === 1'b1);
        repeat (4) @(posedge clk);
        if (paused !== 1'b1) begin
            failure_count++;
            $display("core is not paused after reset");
        end
        check_pc("peek_pc_o", peek_pc, '0);
        check_word("peek_ir_o", peek_ir, '0);

        write_program(START_A, PROG_LEN);
        seed_registers();
        halt_a = run_model(START_A);
        run_program(START_A, halt_a);
        compare_req = 1'b1;
        wait (!compare_req);

        // second program continues from the registers left by the first
        write_program(START_B, PROG_LEN);
        halt_b = run_model(START_B);
        run_program(START_B, halt_b);
        compare_req = 1'b1;
        wait (!compare_req);

        $display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/reindeer_pkg.sv
verilog/reindeer_controller.sv
verilog/reindeer_fetch.sv
verilog/reindeer_decode.sv
verilog/reindeer_reg_file.sv
verilog/reindeer_execute.sv
verilog/reindeer_core.sv
sim/tb_clock_gen.sv
sim/tb_reindeer.sv
